// File: Makefile
VERILATOR ?= verilator
TOP ?= tbCore
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tbChecker.sv
module tbChecker (
  input  logic clk,
  input  logic memReq,
  input  logic memWe,
  input  logic [31:0] memAddr,
  input  logic [31:0] memWdata,
  input  logic halted,
  input  logic testActive,
  input  logic endTest,
  input  logic [95:0] testName,
  input  logic [31:0] expAddr [8],
  input  logic [31:0] expData [8],
  input  int expCount,
  output int valueErrors,
  output int countErrors
);

  int seen;

  initial begin
    valueErrors = 0;
    countErrors = 0;
    seen = 0;
  end

  // levels are stable half a cycle before the write edge
  always @(negedge clk) begin
    if (testActive && memReq && memWe) begin
      if (halted) begin
        countErrors++;
        $display("test %0s: store to %h after halt", testName, memAddr);
      end
      if (seen >= expCount) begin
        countErrors++;
        $display("test %0s: unexpected store of %h to %h", testName, memWdata, memAddr);
      end else begin
        if (memAddr !== expAddr[seen]) begin
          valueErrors++;
          $display("ERR test %0s store %0d addr: expected %h, actual %h",
                   testName, seen, expAddr[seen], memAddr);
        end
        if (memWdata !== expData[seen]) begin
          valueErrors++;
          $display("ERR test %0s store %0d data: expected %h, actual %h",
                   testName, seen, expData[seen], memWdata);
        end
      end
      seen++;
    end
    if (endTest) begin
      if (seen < expCount) begin
        countErrors++;
        $display("test %0s: only %0d of %0d stores seen", testName, seen, expCount);
      end
      seen = 0;
    end
  end

endmodule

// File: verif/tbCore.sv
module tbCore;

  localparam int numTests = 6;
  localparam int progWords = 12;
  localparam int maxStores = 8;
  localparam int clkPeriod = 8;
  localparam int cyclesPerTest = 200;
  localparam logic [31:0] nopWord = 32'h0000_0013;
  localparam logic [31:0] ecallWord = 32'h0000_0073;

  logic clk;
  logic rstN;
  logic [31:0] memRdata;
  logic memReq;
  logic memWe;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic halted;

  logic [31:0] mem [256];   // word-addressed, combinational read

  // test table
  logic [95:0] names [numTests];
  logic [31:0] prog [numTests][progWords];
  logic [31:0] dataWords [numTests][2];
  logic [31:0] expAddrs [numTests][maxStores];
  logic [31:0] expDatas [numTests][maxStores];
  int expCounts [numTests];

  // row handed to the checker
  logic [95:0] curName;
  logic [31:0] curAddr [maxStores];
  logic [31:0] curData [maxStores];
  int curCount;
  logic testActive;
  logic endTest;
  int valueErrors;
  int countErrors;

  coreTop i_dut (
    .clk, .rstN, .memRdata, .memReq, .memWe, .memAddr, .memWdata, .halted
  );

  tbChecker i_checker (
    .clk, .memReq, .memWe, .memAddr, .memWdata, .halted, .testActive, .endTest,
    .testName(curName), .expAddr(curAddr), .expData(curData), .expCount(curCount),
    .valueErrors, .countErrors
  );

  always #(clkPeriod / 2) clk = ~clk;

  assign memRdata = mem[memAddr[9:2]];

  always @(posedge clk) begin
    if (memReq && memWe) begin
      mem[memAddr[9:2]] <= memWdata;
    end
  end

  function automatic logic [31:0] rFormat(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    rFormat = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] iFormat(input logic [6:0] op, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    iFormat = {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] swWord(input logic [4:0] rs2, input logic [11:0] imm,
                                         input logic [4:0] rs1);
    swWord = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] bFormat(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    bFormat = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic addStore(input int t, input logic [31:0] addr, input logic [31:0] data);
    expAddrs[t][expCounts[t]] = addr;
    expDatas[t][expCounts[t]] = data;
    expCounts[t]++;
  endtask

  task automatic buildTable();
    for (int t = 0; t < numTests; t++) begin
      expCounts[t] = 0;
      dataWords[t][0] = 32'h0;
      dataWords[t][1] = 32'h0;
      for (int k = 0; k < progWords; k++) begin
        prog[t][k] = nopWord;
      end
    end
    // arithmetic, sub and slt with a negative immediate
    names[0] = "aluArith    ";
    prog[0][0] = iFormat(7'b0010011, 12'd7, 5'd0, 3'b000, 5'd1);
    prog[0][1] = iFormat(7'b0010011, -12'sd3, 5'd0, 3'b000, 5'd2);
    prog[0][2] = rFormat(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
    prog[0][3] = rFormat(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);
    prog[0][4] = rFormat(7'h00, 5'd2, 5'd1, 3'b100, 5'd5);
    prog[0][5] = rFormat(7'h00, 5'd1, 5'd2, 3'b010, 5'd6);
    prog[0][6] = swWord(5'd3, 12'h200, 5'd0);
    prog[0][7] = swWord(5'd4, 12'h204, 5'd0);
    prog[0][8] = swWord(5'd5, 12'h208, 5'd0);
    prog[0][9] = swWord(5'd6, 12'h20c, 5'd0);
    prog[0][10] = ecallWord;
    addStore(0, 32'h200, 32'd4);           // 7 + -3
    addStore(0, 32'h204, 32'd10);
    addStore(0, 32'h208, 32'hffff_fffa);   // 7 ^ -3
    addStore(0, 32'h20c, 32'd1);
    // logic ops and slt both ways
    names[1] = "aluLogic    ";
    prog[1][0] = iFormat(7'b0010011, 12'h0f0, 5'd0, 3'b000, 5'd1);
    prog[1][1] = iFormat(7'b0010011, 12'h03c, 5'd0, 3'b000, 5'd2);
    prog[1][2] = rFormat(7'h00, 5'd2, 5'd1, 3'b111, 5'd3);
    prog[1][3] = rFormat(7'h00, 5'd2, 5'd1, 3'b110, 5'd4);
    prog[1][4] = rFormat(7'h00, 5'd2, 5'd1, 3'b010, 5'd5);
    prog[1][5] = iFormat(7'b0010011, 12'hfff, 5'd0, 3'b000, 5'd6);
    prog[1][6] = rFormat(7'h00, 5'd0, 5'd6, 3'b010, 5'd7);
    prog[1][7] = swWord(5'd3, 12'h200, 5'd0);
    prog[1][8] = swWord(5'd4, 12'h204, 5'd0);
    prog[1][9] = swWord(5'd5, 12'h208, 5'd0);
    prog[1][10] = swWord(5'd7, 12'h20c, 5'd0);
    prog[1][11] = ecallWord;
    addStore(1, 32'h200, 32'h30);
    addStore(1, 32'h204, 32'hfc);
    addStore(1, 32'h208, 32'd0);
    addStore(1, 32'h20c, 32'd1);   // -1 < 0
    // producers one and two slots ahead
    names[2] = "forwarding  ";
    prog[2][0] = iFormat(7'b0010011, 12'd5, 5'd0, 3'b000, 5'd1);
    prog[2][1] = iFormat(7'b0010011, 12'd3, 5'd1, 3'b000, 5'd2);
    prog[2][2] = rFormat(7'h00, 5'd1, 5'd2, 3'b000, 5'd3);
    prog[2][3] = rFormat(7'h00, 5'd3, 5'd3, 3'b000, 5'd4);
    prog[2][4] = swWord(5'd4, 12'h200, 5'd0);
    prog[2][5] = rFormat(7'h20, 5'd2, 5'd4, 3'b000, 5'd5);
    prog[2][6] = swWord(5'd5, 12'h204, 5'd0);
    prog[2][7] = ecallWord;
    addStore(2, 32'h200, 32'd26);
    addStore(2, 32'h204, 32'd18);
    // load-use
    names[3] = "loadUse     ";
    dataWords[3][0] = 32'd100;
    dataWords[3][1] = 32'd23;
    prog[3][0] = iFormat(7'b0000011, 12'h100, 5'd0, 3'b010, 5'd1);
    prog[3][1] = iFormat(7'b0000011, 12'h104, 5'd0, 3'b010, 5'd2);
    prog[3][2] = rFormat(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
    prog[3][3] = swWord(5'd3, 12'h200, 5'd0);
    prog[3][4] = iFormat(7'b0000011, 12'h200, 5'd0, 3'b010, 5'd4);
    prog[3][5] = iFormat(7'b0010011, 12'd1, 5'd4, 3'b000, 5'd5);
    prog[3][6] = swWord(5'd5, 12'h204, 5'd0);
    prog[3][7] = ecallWord;
    addStore(3, 32'h200, 32'd123);
    addStore(3, 32'h204, 32'd124);
    // taken beq and bne skip two shadow stores each
    names[4] = "branches    ";
    prog[4][0] = iFormat(7'b0010011, 12'd1, 5'd0, 3'b000, 5'd1);
    prog[4][1] = iFormat(7'b0010011, 12'd1, 5'd0, 3'b000, 5'd2);
    prog[4][2] = bFormat(13'd12, 5'd2, 5'd1, 3'b000);   // beq to 20
    prog[4][3] = swWord(5'd1, 12'h2f0, 5'd0);
    prog[4][4] = swWord(5'd2, 12'h2f4, 5'd0);
    prog[4][5] = bFormat(13'd12, 5'd2, 5'd1, 3'b001);   // bne, falls through
    prog[4][6] = swWord(5'd1, 12'h200, 5'd0);
    prog[4][7] = bFormat(13'd12, 5'd0, 5'd1, 3'b001);   // bne to 40
    prog[4][8] = swWord(5'd1, 12'h2f8, 5'd0);
    prog[4][9] = swWord(5'd1, 12'h2fc, 5'd0);
    prog[4][10] = swWord(5'd2, 12'h204, 5'd0);
    prog[4][11] = ecallWord;
    addStore(4, 32'h200, 32'd1);
    addStore(4, 32'h204, 32'd1);
    // loads and stores against fetch, x0, store behind ecall
    names[5] = "busAndHalt  ";
    dataWords[5][0] = 32'h11;
    dataWords[5][1] = 32'h22;
    prog[5][0] = iFormat(7'b0000011, 12'h100, 5'd0, 3'b010, 5'd1);
    prog[5][1] = swWord(5'd1, 12'h200, 5'd0);
    prog[5][2] = iFormat(7'b0000011, 12'h104, 5'd0, 3'b010, 5'd2);
    prog[5][3] = swWord(5'd2, 12'h204, 5'd0);
    prog[5][4] = iFormat(7'b0010011, 12'd55, 5'd0, 3'b000, 5'd0);
    prog[5][5] = swWord(5'd0, 12'h208, 5'd0);
    prog[5][6] = ecallWord;
    prog[5][7] = swWord(5'd1, 12'h20c, 5'd0);
    addStore(5, 32'h200, 32'h11);
    addStore(5, 32'h204, 32'h22);
    addStore(5, 32'h208, 32'h0);
  endtask

  task automatic loadTest(input int t);
    for (int i = 0; i < 256; i++) begin
      mem[i] <= 32'hdead_0000 | i;   // background pattern, unique per word
    end
    for (int k = 0; k < progWords + 4; k++) begin
      mem[k] <= (k < progWords) ? prog[t][k] : nopWord;
    end
    mem[64] <= dataWords[t][0];   // 0x100
    mem[65] <= dataWords[t][1];
    curName = names[t];
    curCount = expCounts[t];
    for (int s = 0; s < maxStores; s++) begin
      curAddr[s] = expAddrs[t][s];
      curData[s] = expDatas[t][s];
    end
  endtask

  // watchdog
  initial begin
    #(numTests * cyclesPerTest * clkPeriod);
    $display("timeout: test %0s never reached halt", curName);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    testActive = 1'b0;
    endTest = 1'b0;
    curName = "none        ";
    curCount = 0;
    buildTable();
    for (int t = 0; t < numTests; t++) begin
      loadTest(t);
      rstN = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rstN = 1'b1;
      testActive = 1'b1;
      while (!halted) @(posedge clk);
      repeat (2) @(posedge clk);   // let anything behind ecall show up
      #1;
      endTest = 1'b1;
      testActive = 1'b0;
      @(posedge clk);
      #1;
      endTest = 1'b0;
    end
    $display("errors: %0d value, %0d store count", valueErrors, countErrors);
    if (valueErrors + countErrors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
verilog/corePkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/busArbiter.sv
verilog/registerFile.sv
verilog/coreTop.sv
verif/tbChecker.sv
verif/tbCore.sv

// File: verilog/busArbiter.sv
module busArbiter import corePkg::*; (
  input  logic dataReq,
  input  logic dataWe,
  input  logic [dataWidth-1:0] dataAddr,
  input  logic [dataWidth-1:0] dataWdata,
  input  logic [dataWidth-1:0] fetchAddr,
  output logic memReq,
  output logic memWe,
  output logic [dataWidth-1:0] memAddr,
  output logic [dataWidth-1:0] memWdata,
  output logic busBusy
);

  // data port has fixed priority, fetch reads whenever it is idle
  assign busBusy = dataReq;
  assign memReq = 1'b1;   // one of the two ports always uses the bus
  assign memWe = dataReq && dataWe;
  assign memAddr = dataReq ? dataAddr : fetchAddr;
  assign memWdata = dataWdata;

endmodule

// File: verilog/corePkg.sv
package corePkg;

  localparam int dataWidth = 32;    // data and address width
  localparam int regAddrWidth = 5;
  localparam int aluOpWidth = 3;
  localparam int bypassWidth = 2;

  // major opcodes of the supported subset
  localparam logic [6:0] opOp = 7'b0110011;
  localparam logic [6:0] opOpImm = 7'b0010011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opSystem = 7'b1110011;   // ecall, used as halt

  localparam logic [aluOpWidth-1:0] aluAdd = 3'd0;
  localparam logic [aluOpWidth-1:0] aluSub = 3'd1;
  localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
  localparam logic [aluOpWidth-1:0] aluOr = 3'd3;
  localparam logic [aluOpWidth-1:0] aluXor = 3'd4;
  localparam logic [aluOpWidth-1:0] aluSlt = 3'd5;
  localparam logic [aluOpWidth-1:0] aluNone = 3'd7;

  // where an execute operand comes from
  localparam logic [bypassWidth-1:0] bypassNone = 2'd0;   // register file value
  localparam logic [bypassWidth-1:0] bypassExec = 2'd1;   // producer was in execute
  localparam logic [bypassWidth-1:0] bypassMem = 2'd2;    // producer was in memory

  localparam logic [dataWidth-1:0] nopInst = 32'h0000_0013;   // addi x0,x0,0
  localparam logic [dataWidth-1:0] resetPc = 32'h0000_0000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rType;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } iType;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sType;

  typedef struct packed {
    logic immBit12;
    logic [5:0] immHi;    // imm[10:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] immLo;    // imm[4:1]
    logic immBit11;
    logic [6:0] opcode;
  } bType;

  // one instruction word, read per format
  typedef union packed {
    rType r;
    iType i;
    sType s;
    bType b;
  } instWord;

endpackage

// File: verilog/coreTop.sv
module coreTop import corePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic [dataWidth-1:0] memRdata,
  output logic memReq,
  output logic memWe,
  output logic [dataWidth-1:0] memAddr,
  output logic [dataWidth-1:0] memWdata,
  output logic halted
);

  logic [dataWidth-1:0] fetchAddr;
  logic [dataWidth-1:0] pc;
  instWord inst;
  logic [regAddrWidth-1:0] rs1Addr;
  logic [regAddrWidth-1:0] rs2Addr;
  logic [dataWidth-1:0] rs1Data;
  logic [dataWidth-1:0] rs2Data;
  logic stall;
  logic [bypassWidth-1:0] op1Bypass;
  logic [bypassWidth-1:0] op2Bypass;
  logic [dataWidth-1:0] exPc;
  logic [dataWidth-1:0] exRs1Data;
  logic [dataWidth-1:0] exRs2Data;
  logic [dataWidth-1:0] exImm;
  logic [aluOpWidth-1:0] exAluOp;
  logic [bypassWidth-1:0] exOp1Bypass;
  logic [bypassWidth-1:0] exOp2Bypass;
  logic exUseImm;
  logic [regAddrWidth-1:0] exRdAddr;
  logic exRegWrite;
  logic exIsLoad;
  logic exIsStore;
  logic exIsBranch;
  logic exBranchNe;
  logic exIsHalt;
  logic branchMiss;
  logic [dataWidth-1:0] branchTarget;
  logic [regAddrWidth-1:0] memRdAddr;
  logic memRegWrite;
  logic memIsLoad;
  logic memIsStore;
  logic memIsHalt;
  logic [dataWidth-1:0] memAluResult;
  logic [dataWidth-1:0] memStoreData;
  logic dataReq;
  logic dataWe;
  logic [dataWidth-1:0] dataAddr;
  logic [dataWidth-1:0] dataWdata;
  logic wbEnable;
  logic [regAddrWidth-1:0] wbAddr;
  logic [dataWidth-1:0] wbData;
  logic busBusy;

  fetchStage i_fetch (
    .clk, .rstN, .stall, .branchMiss, .branchTarget, .halted, .memRdata,
    .fetchAddr, .pc, .inst
  );

  decodeStage i_decode (
    .clk, .rstN, .pc, .inst, .stall, .branchMiss, .op1Bypass, .op2Bypass,
    .rs1Data, .rs2Data, .rs1Addr, .rs2Addr,
    .exPc, .exRs1Data, .exRs2Data, .exImm, .exAluOp, .exOp1Bypass, .exOp2Bypass,
    .exUseImm, .exRdAddr, .exRegWrite, .exIsLoad, .exIsStore, .exIsBranch,
    .exBranchNe, .exIsHalt
  );

  registerFile i_regFile (
    .clk, .rstN, .rs1Addr, .rs2Addr, .wbEnable, .wbAddr, .wbData, .rs1Data, .rs2Data
  );

  hazardUnit i_hazard (
    .rs1Addr, .rs2Addr, .exRdAddr, .exRegWrite, .exIsLoad, .memRdAddr, .memRegWrite,
    .busBusy, .halted, .stall, .op1Bypass, .op2Bypass
  );

  executeStage i_execute (
    .clk, .rstN, .exPc, .exRs1Data, .exRs2Data, .exImm, .exAluOp, .exOp1Bypass,
    .exOp2Bypass, .exUseImm, .exRdAddr, .exRegWrite, .exIsLoad, .exIsStore,
    .exIsBranch, .exBranchNe, .exIsHalt, .wbData,
    .aluResult(),   // forwarded one stage later through wbData
    .branchMiss, .branchTarget, .memRdAddr, .memRegWrite, .memIsLoad, .memIsStore,
    .memIsHalt, .memAluResult, .memStoreData
  );

  memoryStage i_memory (
    .clk, .rstN, .memRdAddr, .memRegWrite, .memIsLoad, .memIsStore, .memIsHalt,
    .memAluResult, .memStoreData, .memRdata, .dataReq, .dataWe, .dataAddr,
    .dataWdata, .wbEnable, .wbAddr, .wbData, .halted
  );

  busArbiter i_arbiter (
    .dataReq, .dataWe, .dataAddr, .dataWdata, .fetchAddr,
    .memReq, .memWe, .memAddr, .memWdata, .busBusy
  );

endmodule

// File: verilog/decodeStage.sv
module decodeStage import corePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic [dataWidth-1:0] pc,
  input  instWord inst,
  input  logic stall,
  input  logic branchMiss,
  input  logic [bypassWidth-1:0] op1Bypass,
  input  logic [bypassWidth-1:0] op2Bypass,
  input  logic [dataWidth-1:0] rs1Data,
  input  logic [dataWidth-1:0] rs2Data,
  output logic [regAddrWidth-1:0] rs1Addr,
  output logic [regAddrWidth-1:0] rs2Addr,
  output logic [dataWidth-1:0] exPc,
  output logic [dataWidth-1:0] exRs1Data,
  output logic [dataWidth-1:0] exRs2Data,
  output logic [dataWidth-1:0] exImm,
  output logic [aluOpWidth-1:0] exAluOp,
  output logic [bypassWidth-1:0] exOp1Bypass,
  output logic [bypassWidth-1:0] exOp2Bypass,
  output logic exUseImm,
  output logic [regAddrWidth-1:0] exRdAddr,
  output logic exRegWrite,
  output logic exIsLoad,
  output logic exIsStore,
  output logic exIsBranch,
  output logic exBranchNe,
  output logic exIsHalt
);

  logic [dataWidth-1:0] imm;
  logic [aluOpWidth-1:0] aluOp;
  logic useImm;
  logic usesRs2;
  logic regWrite;
  logic isLoad;
  logic isStore;
  logic isBranch;
  logic isHalt;
  logic bubble;

  function automatic logic [aluOpWidth-1:0] aluFromFunct(input logic [2:0] funct3,
                                                          input logic alt);
    case (funct3)
      3'b000: aluFromFunct = alt ? aluSub : aluAdd;
      3'b010: aluFromFunct = aluSlt;
      3'b100: aluFromFunct = aluXor;
      3'b110: aluFromFunct = aluOr;
      3'b111: aluFromFunct = aluAnd;
      default: aluFromFunct = aluNone;
    endcase
  endfunction

  assign rs1Addr = inst.r.rs1;
  assign rs2Addr = usesRs2 ? inst.r.rs2 : '0;   // i-type bits are no register
  assign bubble = stall || branchMiss;

  always_comb begin
    imm = '0;
    aluOp = aluNone;
    useImm = 1'b0;
    usesRs2 = 1'b0;
    regWrite = 1'b0;
    isLoad = 1'b0;
    isStore = 1'b0;
    isBranch = 1'b0;
    isHalt = 1'b0;
    case (inst.r.opcode)
      opOp: begin
        aluOp = aluFromFunct(inst.r.funct3, inst.r.funct7[5]);
        usesRs2 = 1'b1;
        regWrite = 1'b1;
      end
      opOpImm: begin
        aluOp = aluFromFunct(inst.i.funct3, 1'b0);
        imm = {{20{inst.i.imm[11]}}, inst.i.imm};
        useImm = 1'b1;
        regWrite = 1'b1;
      end
      opLoad: begin
        aluOp = aluAdd;    // address = rs1 + imm
        imm = {{20{inst.i.imm[11]}}, inst.i.imm};
        useImm = 1'b1;
        regWrite = 1'b1;
        isLoad = 1'b1;
      end
      opStore: begin
        aluOp = aluAdd;
        imm = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
        useImm = 1'b1;
        usesRs2 = 1'b1;
        isStore = 1'b1;
      end
      opBranch: begin
        imm = {{19{inst.b.immBit12}}, inst.b.immBit12, inst.b.immBit11,
               inst.b.immHi, inst.b.immLo, 1'b0};
        usesRs2 = 1'b1;
        isBranch = 1'b1;
      end
      opSystem: isHalt = 1'b1;
      default: ;
    endcase
  end

  // execute pipe register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exPc <= '0;
      exRs1Data <= '0;
      exRs2Data <= '0;
      exImm <= '0;
      exAluOp <= aluNone;
      exOp1Bypass <= bypassNone;
      exOp2Bypass <= bypassNone;
      exUseImm <= 1'b0;
      exRdAddr <= '0;
      exRegWrite <= 1'b0;
      exIsLoad <= 1'b0;
      exIsStore <= 1'b0;
      exIsBranch <= 1'b0;
      exBranchNe <= 1'b0;
      exIsHalt <= 1'b0;
    end else begin
      exPc <= pc;
      exRs1Data <= rs1Data;
      exRs2Data <= rs2Data;
      exImm <= imm;
      exRdAddr <= inst.r.rd;
      exBranchNe <= inst.b.funct3[0];
      // bubble clears the controls, data passes through
      exAluOp <= bubble ? aluNone : aluOp;
      exOp1Bypass <= bubble ? bypassNone : op1Bypass;
      exOp2Bypass <= bubble ? bypassNone : op2Bypass;
      exUseImm <= !bubble && useImm;
      exRegWrite <= !bubble && regWrite;
      exIsLoad <= !bubble && isLoad;
      exIsStore <= !bubble && isStore;
      exIsBranch <= !bubble && isBranch;
      exIsHalt <= !bubble && isHalt;
    end
  end

endmodule

// File: verilog/executeStage.sv
module executeStage import corePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic [dataWidth-1:0] exPc,
  input  logic [dataWidth-1:0] exRs1Data,
  input  logic [dataWidth-1:0] exRs2Data,
  input  logic [dataWidth-1:0] exImm,
  input  logic [aluOpWidth-1:0] exAluOp,
  input  logic [bypassWidth-1:0] exOp1Bypass,
  input  logic [bypassWidth-1:0] exOp2Bypass,
  input  logic exUseImm,
  input  logic [regAddrWidth-1:0] exRdAddr,
  input  logic exRegWrite,
  input  logic exIsLoad,
  input  logic exIsStore,
  input  logic exIsBranch,
  input  logic exBranchNe,
  input  logic exIsHalt,
  input  logic [dataWidth-1:0] wbData,
  output logic [dataWidth-1:0] aluResult,
  output logic branchMiss,
  output logic [dataWidth-1:0] branchTarget,
  output logic [regAddrWidth-1:0] memRdAddr,
  output logic memRegWrite,
  output logic memIsLoad,
  output logic memIsStore,
  output logic memIsHalt,
  output logic [dataWidth-1:0] memAluResult,
  output logic [dataWidth-1:0] memStoreData
);

  logic [dataWidth-1:0] lastWbData;   // value written back on the last edge
  logic [dataWidth-1:0] rs1Val;
  logic [dataWidth-1:0] rs2Val;
  logic [dataWidth-1:0] op2;
  logic operandsEqual;

  always_comb begin
    case (exOp1Bypass)
      bypassExec: rs1Val = wbData;    // producer now in memory
      bypassMem: rs1Val = lastWbData;
      default: rs1Val = exRs1Data;
    endcase
    case (exOp2Bypass)
      bypassExec: rs2Val = wbData;
      bypassMem: rs2Val = lastWbData;
      default: rs2Val = exRs2Data;
    endcase
  end

  assign op2 = exUseImm ? exImm : rs2Val;

  always_comb begin
    case (exAluOp)
      aluAdd: aluResult = rs1Val + op2;
      aluSub: aluResult = rs1Val - op2;
      aluAnd: aluResult = rs1Val & op2;
      aluOr: aluResult = rs1Val | op2;
      aluXor: aluResult = rs1Val ^ op2;
      aluSlt: aluResult = {31'b0, $signed(rs1Val) < $signed(op2)};
      default: aluResult = '0;
    endcase
  end

  // predicted not-taken, so any taken branch is a miss
  assign operandsEqual = (rs1Val == rs2Val);
  assign branchMiss = exIsBranch && (exBranchNe ? !operandsEqual : operandsEqual);
  assign branchTarget = exPc + exImm;

  // memory pipe register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lastWbData <= '0;
      memRdAddr <= '0;
      memRegWrite <= 1'b0;
      memIsLoad <= 1'b0;
      memIsStore <= 1'b0;
      memIsHalt <= 1'b0;
      memAluResult <= '0;
      memStoreData <= '0;
    end else begin
      lastWbData <= wbData;
      memRdAddr <= exRdAddr;
      memRegWrite <= exRegWrite;
      memIsLoad <= exIsLoad;
      memIsStore <= exIsStore;
      memIsHalt <= exIsHalt;
      memAluResult <= aluResult;
      memStoreData <= rs2Val;   // store data after bypass
    end
  end

endmodule

// File: verilog/fetchStage.sv
module fetchStage import corePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic stall,
  input  logic branchMiss,
  input  logic [dataWidth-1:0] branchTarget,
  input  logic halted,
  input  logic [dataWidth-1:0] memRdata,
  output logic [dataWidth-1:0] fetchAddr,
  output logic [dataWidth-1:0] pc,
  output instWord inst
);

  // fetchAddr is the next word to read, pc belongs to inst
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fetchAddr <= resetPc;
      pc <= resetPc;
      inst <= nopInst;
    end else if (!halted) begin
      if (branchMiss) begin
        fetchAddr <= branchTarget;    // redirect, drop the shadow word
        pc <= branchTarget;
        inst <= nopInst;
      end else if (!stall) begin
        pc <= fetchAddr;
        inst <= memRdata;
        fetchAddr <= fetchAddr + 32'd4;
      end
    end
  end

endmodule

// File: verilog/hazardUnit.sv
module hazardUnit import corePkg::*; (
  input  logic [regAddrWidth-1:0] rs1Addr,
  input  logic [regAddrWidth-1:0] rs2Addr,
  input  logic [regAddrWidth-1:0] exRdAddr,
  input  logic exRegWrite,
  input  logic exIsLoad,
  input  logic [regAddrWidth-1:0] memRdAddr,
  input  logic memRegWrite,
  input  logic busBusy,
  input  logic halted,
  output logic stall,
  output logic [bypassWidth-1:0] op1Bypass,
  output logic [bypassWidth-1:0] op2Bypass
);

  logic rs1ExHit;
  logic rs2ExHit;
  logic rs1MemHit;
  logic rs2MemHit;
  logic loadUse;

  // x0 never forwards
  assign rs1ExHit = exRegWrite && (exRdAddr != '0) && (exRdAddr == rs1Addr);
  assign rs2ExHit = exRegWrite && (exRdAddr != '0) && (exRdAddr == rs2Addr);
  assign rs1MemHit = memRegWrite && (memRdAddr != '0) && (memRdAddr == rs1Addr);
  assign rs2MemHit = memRegWrite && (memRdAddr != '0) && (memRdAddr == rs2Addr);

  // younger producer wins
  assign op1Bypass = rs1ExHit ? bypassExec : (rs1MemHit ? bypassMem : bypassNone);
  assign op2Bypass = rs2ExHit ? bypassExec : (rs2MemHit ? bypassMem : bypassNone);

  assign loadUse = exIsLoad && (rs1ExHit || rs2ExHit);
  assign stall = loadUse || busBusy || halted;

endmodule

// File: verilog/memoryStage.sv
module memoryStage import corePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic [regAddrWidth-1:0] memRdAddr,
  input  logic memRegWrite,
  input  logic memIsLoad,
  input  logic memIsStore,
  input  logic memIsHalt,
  input  logic [dataWidth-1:0] memAluResult,
  input  logic [dataWidth-1:0] memStoreData,
  input  logic [dataWidth-1:0] memRdata,
  output logic dataReq,
  output logic dataWe,
  output logic [dataWidth-1:0] dataAddr,
  output logic [dataWidth-1:0] dataWdata,
  output logic wbEnable,
  output logic [regAddrWidth-1:0] wbAddr,
  output logic [dataWidth-1:0] wbData,
  output logic halted
);

  // nothing behind the halt may touch memory or registers
  assign dataReq = (memIsLoad || memIsStore) && !halted;
  assign dataWe = memIsStore && !halted;
  assign dataAddr = memAluResult;
  assign dataWdata = memStoreData;

  assign wbEnable = memRegWrite && !halted;
  assign wbAddr = memRdAddr;
  assign wbData = memIsLoad ? memRdata : memAluResult;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      halted <= 1'b0;
    end else if (memIsHalt) begin
      halted <= 1'b1;   // sticky until reset
    end
  end

endmodule

// File: verilog/registerFile.sv
module registerFile import corePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic [regAddrWidth-1:0] rs1Addr,
  input  logic [regAddrWidth-1:0] rs2Addr,
  input  logic wbEnable,
  input  logic [regAddrWidth-1:0] wbAddr,
  input  logic [dataWidth-1:0] wbData,
  output logic [dataWidth-1:0] rs1Data,
  output logic [dataWidth-1:0] rs2Data
);

  logic [dataWidth-1:0] regs [2**regAddrWidth];

  // reads see the old value during a write-back cycle
  assign rs1Data = regs[rs1Addr];
  assign rs2Data = regs[rs2Addr];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEnable && (wbAddr != '0)) begin
      regs[wbAddr] <= wbData;   // x0 stays zero
    end
  end

endmodule
